// ==== build.f ====
hw/rx_buff_pkg.sv
hw/rx_ctrl_pkg.sv
hw/rx_ibuff.sv
hw/rx_pkt_writer.sv
hw/rx_len_fifo.sv
hw/rx_pkt_reader.sv
hw/rx_buff_top.sv
verification/rx_buff_tb.sv

// ==== verification/rx_buff_tb.sv ====
// rx packet buffer testbench driving a frame table in a loop against a stream model
module rx_buff_tb;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int TB_ADDR_W   = 7;     // 128-word buffer so pointers wrap often
    localparam int LEN_DEPTH_W = 4;
    localparam int MODE_ON     = 0;     // out_ready always high
    localparam int MODE_RAND   = 1;     // out_ready from $random
    localparam int MODE_HOLD   = 2;     // out_ready low until the input stalls
    localparam int STALL_LIMIT = 16;    // stalled cycles before out_ready comes back

    logic               clk;
    logic               arst_n;
    logic               in_valid;
    logic               in_ready;
    rx_buff_pkg::data_t in_data;
    logic               in_last;
    logic               in_err;
    logic               out_valid;
    logic               out_ready;
    rx_buff_pkg::data_t out_data;
    logic               out_last;
    rx_buff_pkg::cnt_t  drop_count;

    // stimulus table with one row per frame
    string row_name [$];
    int    row_len  [$];
    int    row_off  [$];                // data seed offset
    logic  row_err  [$];
    int    row_mode [$];

    // output stream model of good frames only
    rx_buff_pkg::data_t exp_data [$];
    logic               exp_last [$];
    string              exp_name [$];
    string              exp_n;
    rx_buff_pkg::data_t exp_d;
    logic               exp_l;
    rx_buff_pkg::cnt_t  exp_drops;      // error rows sent so far

    int                 cur_mode;
    logic               released;       // hold group let go
    int                 stall_cnt;
    logic               stalled;        // out_valid without out_ready last edge
    integer             seed;
    int                 rnd_val;
    int                 cycles;
    int                 cycle_limit;

    rx_buff_top #(
        .ADDR_W      (TB_ADDR_W),
        .LEN_DEPTH_W (LEN_DEPTH_W)
    ) rx_buff_top_inst (
        .clk        (clk),
        .arst_n     (arst_n),
        .in_valid   (in_valid),
        .in_ready   (in_ready),
        .in_data    (in_data),
        .in_last    (in_last),
        .in_err     (in_err),
        .out_valid  (out_valid),
        .out_ready  (out_ready),
        .out_data   (out_data),
        .out_last   (out_last),
        .drop_count (drop_count)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    ////////////////////////////////////////
    // checks
    ////////////////////////////////////////

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("Simulation failed");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_data(input string name, input rx_buff_pkg::data_t exp,
                              input rx_buff_pkg::data_t act);
        if (act !== exp) fail_run($sformatf("Fail %s expected %h actual %h", name, exp, act));
    endtask

    task automatic check_last(input string name, input logic exp, input logic act);
        if (act !== exp) fail_run($sformatf("Fail %s expected %b actual %b", name, exp, act));
    endtask

    task automatic check_drops(input string name, input rx_buff_pkg::cnt_t exp,
                               input rx_buff_pkg::cnt_t act);
        if (act !== exp) fail_run($sformatf("Fail %s expected %0d actual %0d", name, exp, act));
    endtask

    ////////////////////////////////////////
    // stimulus table
    ////////////////////////////////////////

    task automatic add_row(input string name, input int len, input int off,
                           input logic err, input int mode);
        row_name.push_back(name);
        row_len.push_back(len);
        row_off.push_back(off);
        row_err.push_back(err);
        row_mode.push_back(mode);
    endtask

    task automatic build_table();
        int i;
        add_row("single_word", 1, 1, 1'b0, MODE_ON);
        add_row("two_words", 2, 2, 1'b0, MODE_ON);
        add_row("max_len", 40, 3, 1'b0, MODE_ON);
        add_row("odd_len", 17, 4, 1'b0, MODE_ON);
        // error frames with good ones right behind them
        add_row("err_short", 5, 5, 1'b1, MODE_ON);
        add_row("after_err", 8, 6, 1'b0, MODE_ON);
        add_row("err_long", 33, 7, 1'b1, MODE_ON);
        add_row("err_single", 1, 8, 1'b1, MODE_ON);
        add_row("after_two_err", 40, 9, 1'b0, MODE_ON);
        add_row("rand_short", 3, 10, 1'b0, MODE_RAND);
        add_row("rand_max", 40, 11, 1'b0, MODE_RAND);
        add_row("rand_err", 12, 12, 1'b1, MODE_RAND);
        add_row("rand_single", 1, 13, 1'b0, MODE_RAND);
        add_row("rand_mid", 29, 14, 1'b0, MODE_RAND);
        // output held off until buffer space runs out
        for (i = 0; i < 5; i++) begin
            add_row($sformatf("hold_fill_%0d", i), 40, 20 + i, 1'b0, MODE_HOLD);
        end
        add_row("sep_fill", 4, 30, 1'b0, MODE_ON);
        // short frames so the length fifo fills first
        for (i = 0; i < 20; i++) begin
            add_row($sformatf("hold_fifo_%0d", i), 2, 40 + i, 1'b0, MODE_HOLD);
        end
        add_row("sep_fifo", 4, 70, 1'b0, MODE_ON);
        // mixed traffic that wraps both banks several times
        for (i = 0; i < 30; i++) begin
            add_row($sformatf("wrap_%0d", i), 1 + (i * 13) % 40, 100 + i, (i % 5) == 3,
                    (i % 2) ? MODE_RAND : MODE_ON);
        end
    endtask

    // word pattern unique per frame and position
    function automatic rx_buff_pkg::data_t make_word(input int off, input int idx);
        logic [15:0] o;
        logic [15:0] w;
        o = off[15:0];
        w = idx[15:0];
        return {o ^ 16'h5a5a, w, ~o, w ^ 16'h3c3c};
    endfunction

    task automatic queue_expected(input int row);
        int i;
        for (i = 0; i < row_len[row]; i++) begin
            exp_data.push_back(make_word(row_off[row], i));
            exp_last.push_back(i == row_len[row] - 1);
            exp_name.push_back(row_name[row]);
        end
    endtask

    // one word per accepted edge and waits out in_ready
    task automatic send_frame(input int row);
        int i;
        for (i = 0; i < row_len[row]; i++) begin
            in_valid <= 1'b1;
            in_data  <= make_word(row_off[row], i);
            in_last  <= (i == row_len[row] - 1);
            in_err   <= (i == row_len[row] - 1) ? row_err[row] : i[0]; // ignored mid-frame
            @(posedge clk);
            while (!in_ready) @(posedge clk);
        end
        in_valid <= 1'b0;
        in_last  <= 1'b0;
        in_err   <= 1'b0;
    endtask

    ////////////////////////////////////////
    // output side
    ////////////////////////////////////////

    always @(posedge clk) begin
        rnd_val = $random(seed);
        case (cur_mode)
            MODE_RAND: out_ready <= rnd_val[0];
            MODE_HOLD: out_ready <= released;
            default:   out_ready <= 1'b1;
        endcase
    end

    // let a held group go once the input has been stuck a while
    always @(posedge clk) begin
        if (cur_mode == MODE_HOLD && !released) begin
            stall_cnt <= (in_valid && !in_ready) ? stall_cnt + 1 : 0;
            if (stall_cnt >= STALL_LIMIT) released <= 1'b1;
        end else begin
            stall_cnt <= 0;
        end
    end

    // an offered word must match the model head until it is taken
    always @(posedge clk) begin
        if (arst_n) begin
            if (stalled) begin                      // stalled word must stay offered
                check_last("out_valid held", 1'b1, out_valid);
            end
            if (out_valid) begin
                if (exp_data.size() == 0) begin
                    fail_run("output word seen while no good frame was pending");
                end else begin
                    exp_n = exp_name[0];
                    exp_d = exp_data[0];
                    exp_l = exp_last[0];
                    check_data(exp_n, exp_d, out_data);
                    check_last(exp_n, exp_l, out_last);
                    if (out_ready) begin            // word taken so the next one is due
                        void'(exp_name.pop_front());
                        void'(exp_data.pop_front());
                        void'(exp_last.pop_front());
                    end
                end
            end
            stalled <= out_valid && !out_ready;
        end
    end

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycle_limit > 0 && cycles > cycle_limit) begin
            fail_run($sformatf("timeout: run did not finish within %0d cycles", cycle_limit));
        end
    end

    ////////////////////////////////////////
    // main sequence
    ////////////////////////////////////////

    initial begin
        int r;
        int total;
        arst_n    = 1'b0;
        in_valid  = 1'b0;
        in_data   = '0;
        in_last   = 1'b0;
        in_err    = 1'b0;
        out_ready = 1'b0;
        cur_mode  = MODE_ON;
        released  = 1'b0;
        stall_cnt = 0;
        stalled   = 1'b0;
        exp_drops = '0;
        seed      = 5431;
        cycles    = 0;
        build_table();
        total = 0;
        for (r = 0; r < row_len.size(); r++) total += row_len[r];
        cycle_limit = total * 8 + 1000;

        repeat (8) @(posedge clk);
        arst_n <= 1'b1;
        @(posedge clk);
        check_last("reset out_valid", 1'b0, out_valid);
        check_last("reset in_ready", 1'b1, in_ready);
        check_drops("reset drop_count", '0, drop_count);

        for (r = 0; r < row_len.size(); r++) begin
            cur_mode <= row_mode[r];
            if (row_mode[r] != MODE_HOLD) released <= 1'b0;    // rearm next hold group
            if (!row_err[r]) queue_expected(r);
            send_frame(r);
            if (row_err[r]) exp_drops = exp_drops + 1'b1;
            @(posedge clk);                                     // counter lands here
            check_drops(row_name[r], exp_drops, drop_count);
        end

        // drain whatever is still buffered
        cur_mode <= MODE_ON;
        while (exp_data.size() != 0) @(posedge clk);
        repeat (10) @(posedge clk);
        check_drops("final drop_count", exp_drops, drop_count);
        if (out_valid) begin
            fail_run("output still valid after every expected word arrived");
        end else begin
            $display("Simulation passed");
            $finish;
        end
    end

endmodule : rx_buff_tb

// ==== hw/rx_buff_top.sv ====
// rx packet buffer top: writer, length fifo, internal buffer and reader
module rx_buff_top #(
    parameter int ADDR_W      = 10,
    parameter int LEN_DEPTH_W = 4
) (
    input  logic               clk,
    input  logic               arst_n,
    input  logic               in_valid,
    output logic               in_ready,
    input  rx_buff_pkg::data_t in_data,
    input  logic               in_last,
    input  logic               in_err,
    output logic               out_valid,
    input  logic               out_ready,
    output rx_buff_pkg::data_t out_data,
    output logic               out_last,
    output rx_buff_pkg::cnt_t  drop_count
);

    logic [ADDR_W-1:0]  wr_addr;            // writer to buffer
    rx_buff_pkg::data_t wr_data;
    logic [ADDR_W-1:0]  rd_addr;            // reader to buffer
    rx_buff_pkg::data_t rd_data;
    logic [ADDR_W-1:0]  free_ptr;           // reader back to writer
    logic               push;               // writer to length fifo
    rx_buff_pkg::len_t  push_len;
    logic               fifo_full;
    logic               pop;                // length fifo to reader
    rx_buff_pkg::len_t  pop_len;
    logic               fifo_empty;

    ////////////////////////////////////////
    // write side
    ////////////////////////////////////////

    rx_pkt_writer #(
        .ADDR_W     (ADDR_W)
    ) rx_pkt_writer_inst (
        .clk        (clk),
        .arst_n     (arst_n),
        .in_valid   (in_valid),
        .in_ready   (in_ready),
        .in_data    (in_data),
        .in_last    (in_last),
        .in_err     (in_err),
        .wr_addr    (wr_addr),
        .wr_data    (wr_data),
        .free_ptr   (free_ptr),
        .fifo_full  (fifo_full),
        .push       (push),
        .push_len   (push_len),
        .drop_count (drop_count)
    );

    rx_len_fifo #(
        .LEN_DEPTH_W (LEN_DEPTH_W)
    ) rx_len_fifo_inst (
        .clk      (clk),
        .arst_n   (arst_n),
        .push     (push),
        .push_len (push_len),
        .pop      (pop),
        .pop_len  (pop_len),
        .empty    (fifo_empty),
        .full     (fifo_full)
    );

    ////////////////////////////////////////
    // storage and read side
    ////////////////////////////////////////

    rx_ibuff #(
        .ADDR_W  (ADDR_W)
    ) rx_ibuff_inst (
        .clk     (clk),
        .wr_addr (wr_addr),
        .wr_data (wr_data),
        .rd_addr (rd_addr),
        .rd_data (rd_data)
    );

    rx_pkt_reader #(
        .ADDR_W    (ADDR_W)
    ) rx_pkt_reader_inst (
        .clk       (clk),
        .arst_n    (arst_n),
        .empty     (fifo_empty),
        .pop       (pop),
        .pop_len   (pop_len),
        .rd_addr   (rd_addr),
        .rd_data   (rd_data),
        .free_ptr  (free_ptr),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .out_data  (out_data),
        .out_last  (out_last)
    );

endmodule : rx_buff_top

// ==== hw/rx_pkt_reader.sv ====
// rx packet reader: fetches stored frames and streams them out with back-pressure
module rx_pkt_reader #(
    parameter int ADDR_W = 10
) (
    input  logic               clk,
    input  logic               arst_n,
    input  logic               empty,
    output logic               pop,
    input  rx_buff_pkg::len_t  pop_len,
    output logic [ADDR_W-1:0]  rd_addr,
    input  rx_buff_pkg::data_t rd_data,
    output logic [ADDR_W-1:0]  free_ptr,
    output logic               out_valid,
    input  logic               out_ready,
    output rx_buff_pkg::data_t out_data,
    output logic               out_last
);

    rx_ctrl_pkg::rd_state_t state;

    logic [ADDR_W-1:0]  rd_ptr;             // next word to fetch
    logic [ADDR_W-1:0]  free_q;             // next word to leave
    rx_buff_pkg::len_t  remain;             // reads left in this frame
    logic [1:0]         v_sr;               // reads in flight, bit 1 is data now
    logic [1:0]         l_sr;               // last tag riding with v_sr
    rx_buff_pkg::data_t skid_data [3];
    logic [2:0]         skid_last;
    logic [1:0]         wr_idx;             // skid slot for next landing word
    logic [1:0]         rd_idx;             // skid slot at the output
    logic [1:0]         skid_cnt;
    logic [2:0]         committed;          // slots spoken for next cycle
    logic               issue;
    logic               take;
    logic               give;

    ////////////////////////////////////////
    // read issue
    ////////////////////////////////////////

    assign pop  = (state == rx_ctrl_pkg::rd_idle) && !empty;
    assign give = out_valid && out_ready;   // word leaves
    assign take = v_sr[1];                  // word lands in the skid store

    // a slot freed this cycle may be claimed right away
    assign committed = {1'b0, skid_cnt} - {2'b00, give}
                       + {2'b00, v_sr[0]} + {2'b00, v_sr[1]};
    assign issue     = (state == rx_ctrl_pkg::rd_fetch) && (committed < 3'd3);

    assign rd_addr  = rd_ptr;               // buffer samples it every edge
    assign free_ptr = free_q;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state  <= rx_ctrl_pkg::rd_idle;
            rd_ptr <= '0;
            remain <= '0;
            v_sr   <= 2'b00;
            l_sr   <= 2'b00;
        end else begin
            v_sr <= {v_sr[0], issue};
            l_sr <= {l_sr[0], issue && (remain == rx_buff_pkg::len_t'(1))};
            case (state)
                rx_ctrl_pkg::rd_idle: begin
                    if (pop) begin
                        remain <= pop_len;
                        state  <= rx_ctrl_pkg::rd_fetch;
                    end
                end
                rx_ctrl_pkg::rd_fetch: begin
                    if (issue) begin
                        rd_ptr <= rd_ptr + 1'b1;
                        remain <= remain - 1'b1;
                        if (remain == rx_buff_pkg::len_t'(1)) begin
                            state <= rx_ctrl_pkg::rd_drain;
                        end
                    end
                end
                rx_ctrl_pkg::rd_drain: begin
                    if (v_sr == 2'b00) begin          // final word has landed
                        state <= rx_ctrl_pkg::rd_idle;
                    end
                end
                default: begin
                    state <= rx_ctrl_pkg::rd_idle;
                end
            endcase
        end
    end

    ////////////////////////////////////////
    // skid store and output
    ////////////////////////////////////////

    assign out_valid = (skid_cnt != 2'd0);
    assign out_data  = skid_data[rd_idx];
    assign out_last  = skid_last[rd_idx];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wr_idx   <= 2'd0;
            rd_idx   <= 2'd0;
            skid_cnt <= 2'd0;
            free_q   <= '0;
        end else begin
            if (take) begin
                wr_idx <= (wr_idx == 2'd2) ? 2'd0 : wr_idx + 2'd1;
            end
            if (give) begin
                rd_idx <= (rd_idx == 2'd2) ? 2'd0 : rd_idx + 2'd1;
                free_q <= free_q + 1'b1;      // buffer word released
            end
            case ({take, give})
                2'b10:   skid_cnt <= skid_cnt + 2'd1;
                2'b01:   skid_cnt <= skid_cnt - 2'd1;
                default: skid_cnt <= skid_cnt;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            skid_data[wr_idx] <= rd_data;     // read from two edges back
            skid_last[wr_idx] <= l_sr[1];
        end
    end

endmodule : rx_pkt_reader

// ==== hw/rx_len_fifo.sv ====
// rx length fifo: queues committed frame lengths from writer to reader
module rx_len_fifo #(
    parameter int LEN_DEPTH_W = 4
) (
    input  logic              clk,
    input  logic              arst_n,
    input  logic              push,
    input  rx_buff_pkg::len_t push_len,
    input  logic              pop,
    output rx_buff_pkg::len_t pop_len,
    output logic              empty,
    output logic              full
);

    localparam int DEPTH = 1 << LEN_DEPTH_W;

    rx_buff_pkg::len_t      mem [DEPTH];    // length slots
    logic [LEN_DEPTH_W-1:0] wr_ptr;
    logic [LEN_DEPTH_W-1:0] rd_ptr;
    logic [LEN_DEPTH_W:0]   count;          // 0 .. DEPTH
    logic                   do_push;
    logic                   do_pop;

    // ignore requests that would break the fifo
    assign do_push = push && !full;
    assign do_pop  = pop && !empty;

    assign empty   = (count == '0);
    assign full    = count[LEN_DEPTH_W];    // msb set only at DEPTH
    assign pop_len = mem[rd_ptr];           // show-ahead head

    ////////////////////////////////////////
    // pointers and occupancy
    ////////////////////////////////////////

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= wr_ptr + 1'b1;    // wraps at DEPTH
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;    // both or neither
            endcase
        end
    end

    // storage
    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= push_len;
        end
    end

endmodule : rx_len_fifo

// ==== hw/rx_pkt_writer.sv ====
// rx packet writer: stores input frames, rewinds on error frames, commits good lengths
module rx_pkt_writer #(
    parameter int ADDR_W = 10
) (
    input  logic               clk,
    input  logic               arst_n,
    input  logic               in_valid,
    output logic               in_ready,
    input  rx_buff_pkg::data_t in_data,
    input  logic               in_last,
    input  logic               in_err,
    output logic [ADDR_W-1:0]  wr_addr,
    output rx_buff_pkg::data_t wr_data,
    input  logic [ADDR_W-1:0]  free_ptr,
    input  logic               fifo_full,
    output logic               push,
    output rx_buff_pkg::len_t  push_len,
    output rx_buff_pkg::cnt_t  drop_count
);

    rx_ctrl_pkg::wr_state_t state;

    logic [ADDR_W-1:0] wr_ptr;          // next free word
    logic [ADDR_W-1:0] start_ptr;       // first word of the current frame
    logic [ADDR_W-1:0] used;            // words not yet handed out by the reader
    rx_buff_pkg::len_t frame_len;       // words accepted so far in this frame
    rx_buff_pkg::len_t commit_len;      // length waiting for the fifo
    logic              settle;          // second commit cycle reached
    logic              accept;

    ////////////////////////////////////////
    // flow control
    ////////////////////////////////////////

    // one word kept spare so full and empty never alias
    assign used     = wr_ptr - free_ptr;
    assign in_ready = (state != rx_ctrl_pkg::wr_commit) && !fifo_full
                      && (used != {ADDR_W{1'b1}});
    assign accept   = in_valid && in_ready;

    // length goes out only once the last word is in memory
    assign push     = (state == rx_ctrl_pkg::wr_commit) && settle && !fifo_full;
    assign push_len = commit_len;

    ////////////////////////////////////////
    // frame fsm and pointers
    ////////////////////////////////////////

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state      <= rx_ctrl_pkg::wr_idle;
            wr_ptr     <= '0;
            start_ptr  <= '0;
            frame_len  <= '0;
            settle     <= 1'b0;
            drop_count <= '0;
            wr_addr    <= '0;
        end else begin
            case (state)
                rx_ctrl_pkg::wr_idle, rx_ctrl_pkg::wr_frame: begin
                    if (accept) begin
                        wr_addr <= wr_ptr;                  // pair goes to the buffer
                        if (!in_last) begin
                            wr_ptr    <= wr_ptr + 1'b1;
                            frame_len <= frame_len + 1'b1;
                            state     <= rx_ctrl_pkg::wr_frame;
                        end else if (in_err) begin
                            // discard, next frame reuses the same space
                            wr_ptr     <= start_ptr;
                            frame_len  <= '0;
                            drop_count <= drop_count + 1'b1;
                            state      <= rx_ctrl_pkg::wr_idle;
                        end else begin
                            wr_ptr    <= wr_ptr + 1'b1;
                            start_ptr <= wr_ptr + 1'b1;     // frame kept
                            frame_len <= '0;
                            settle    <= 1'b0;
                            state     <= rx_ctrl_pkg::wr_commit;
                        end
                    end
                end
                rx_ctrl_pkg::wr_commit: begin
                    settle <= 1'b1;                         // first cycle just waits
                    if (push) begin
                        state <= rx_ctrl_pkg::wr_idle;
                    end
                end
                default: begin
                    state <= rx_ctrl_pkg::wr_idle;
                end
            endcase
        end
    end

    ////////////////////////////////////////
    // payload
    ////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (accept) begin
            wr_data <= in_data;                             // held until next word
        end
        if (accept && in_last) begin
            commit_len <= frame_len + 1'b1;                 // count includes last word
        end
    end

endmodule : rx_pkt_writer

// ==== hw/rx_ibuff.sv ====
// rx internal buffer: two-bank frame memory with registered write and read ports
module rx_ibuff #(
    parameter int ADDR_W = 10
) (
    input  logic               clk,
    input  logic [ADDR_W-1:0]  wr_addr,
    input  rx_buff_pkg::data_t wr_data,
    input  logic [ADDR_W-1:0]  rd_addr,
    output rx_buff_pkg::data_t rd_data
);

    // top address bit picks the bank, rest index inside it
    localparam int BANK_WORDS = 1 << (ADDR_W - 1);

    logic [ADDR_W-1:0]  wr_addr_q;                  // write port stage 1
    rx_buff_pkg::data_t wr_data_q;
    logic [ADDR_W-1:0]  rd_addr_q;                  // read port stage 1

    rx_buff_pkg::data_t bank0 [BANK_WORDS];         // lower half of the address space
    rx_buff_pkg::data_t bank1 [BANK_WORDS];         // upper half

    ////////////////////////////////////////
    // write port
    ////////////////////////////////////////

    always_ff @(posedge clk) begin
        wr_addr_q <= wr_addr;
        wr_data_q <= wr_data;
        // word lands one edge after it was captured
        if (!wr_addr_q[ADDR_W-1]) begin
            bank0[wr_addr_q[ADDR_W-2:0]] <= wr_data_q;
        end else begin
            bank1[wr_addr_q[ADDR_W-2:0]] <= wr_data_q;
        end
    end

    ////////////////////////////////////////
    // read port
    ////////////////////////////////////////

    always_ff @(posedge clk) begin
        rd_addr_q <= rd_addr;                       // address captured
        if (!rd_addr_q[ADDR_W-1]) begin             // then bank selected
            rd_data <= bank0[rd_addr_q[ADDR_W-2:0]];
        end else begin
            rd_data <= bank1[rd_addr_q[ADDR_W-2:0]];
        end
    end

endmodule : rx_ibuff

// ==== hw/rx_ctrl_pkg.sv ====
// rx buffer control encodings: writer and reader state machine states
package rx_ctrl_pkg;

    ////////////////////////////////////////
    // writer fsm
    ////////////////////////////////////////

    // wr_commit holds off the length push until the
    // last word has settled in the buffer
    typedef enum logic [1:0] {
        wr_idle   = 2'd0,   // waiting for first word of a frame
        wr_frame  = 2'd1,   // frame in progress
        wr_commit = 2'd2    // good frame stored, length pending
    } wr_state_t;

    ////////////////////////////////////////
    // reader fsm
    ////////////////////////////////////////

    typedef enum logic [1:0] {
        rd_idle  = 2'd0,    // waiting on the length fifo
        rd_fetch = 2'd1,    // issuing buffer reads
        rd_drain = 2'd2     // last read issued, waiting for it to land
    } rd_state_t;

endpackage : rx_ctrl_pkg

// ==== hw/rx_buff_pkg.sv ====
// rx buffer data types: stream word, frame length and drop counter widths
package rx_buff_pkg;

    ////////////////////////////////////////
    // stream word
    ////////////////////////////////////////

    // 64-bit datapath, one ethernet word per beat
    localparam int DATA_W = 64;

    typedef logic [DATA_W-1:0] data_t;   // one stream word

    ////////////////////////////////////////
    // frame bookkeeping
    ////////////////////////////////////////

    // length in words, covers any ADDR_W up to 15
    localparam int LEN_W = 16;

    typedef logic [LEN_W-1:0] len_t;     // committed frame length

    // error frame counter, wraps silently
    localparam int CNT_W = 16;

    typedef logic [CNT_W-1:0] cnt_t;     // drop count value

endpackage : rx_buff_pkg
